/* rx_stream_pkg.sv */
package rx_stream_pkg;

  // geometry of the 64-bit receive stream
  localparam int data_width = 64;

  // one byte enable per byte of tdata
  localparam int keep_width = data_width / 8;

  // a beat carries two dwords, so the first beat holds two header dwords
  localparam int beat_dwords = data_width / 32;

  // tuser of the receive interface
  localparam int tuser_width = 22;

  // end of frame flag in tuser
  localparam int tuser_eof_bit = 21;

  // bit 4 of an is_eof code flags the end of frame
  // bits 3:2 give the offset of the last dword within the beat
  // bits 1:0 always read 11 on this interface
  localparam logic [4:0] eof_code_1dw = 5'b10011;
  localparam logic [4:0] eof_code_2dw = 5'b10111;
  localparam logic [4:0] eof_code_none = 5'b00011;

endpackage

/* tlp_hdr_pkg.sv */
package tlp_hdr_pkg;

  // remaining dword counter, wide enough for a full 1024 dword payload
  // plus the header and digest
  localparam int len_width = 12;

  typedef logic [len_width-1:0] len_t;

  // fields of the first header dword
  // fmt is two bits wide, bit 0 selects a 4-dword header and bit 1 marks data
  localparam int fmt_lsb = 29;

  // TD flags a 1-dword digest at the end of the packet
  localparam int td_bit = 15;

  // payload length in dwords, only meaningful when the packet carries data
  localparam int length_lsb = 0;
  localparam int length_field_width = 10;

  // header sizes in dwords
  localparam int hdr3_dwords = 3;
  localparam int hdr4_dwords = 4;

endpackage

/* tlp_len_decode.sv */
module tlp_len_decode (
  input  logic [rx_stream_pkg::data_width-1:0] tdata,
  output logic [tlp_hdr_pkg::len_width-1:0]    new_pkt_len
);

  logic [1:0]                                 fmt;
  logic                                       td;
  logic [tlp_hdr_pkg::length_field_width-1:0] payload_len;
  logic [3:0]                                 overhead;

  // the first header dword sits in the low half of the starting beat
  assign fmt = tdata[tlp_hdr_pkg::fmt_lsb +: 2];
  assign td  = tdata[tlp_hdr_pkg::td_bit];

  // without data the length field is reserved and must not count
  assign payload_len = fmt[1] ?
      tdata[tlp_hdr_pkg::length_lsb +: tlp_hdr_pkg::length_field_width] : '0;

  // header plus digest, less the dwords already taken by this beat
  always_comb begin
    case ({fmt[0], td})
      2'b00: begin
        overhead = 4'(tlp_hdr_pkg::hdr3_dwords - rx_stream_pkg::beat_dwords);
      end
      2'b01: begin
        overhead = 4'(tlp_hdr_pkg::hdr3_dwords + 1 - rx_stream_pkg::beat_dwords);
      end
      2'b10: begin
        overhead = 4'(tlp_hdr_pkg::hdr4_dwords - rx_stream_pkg::beat_dwords);
      end
      default: begin
        overhead = 4'(tlp_hdr_pkg::hdr4_dwords + 1 - rx_stream_pkg::beat_dwords);
      end
    endcase
  end

  // overhead is treated as signed so that a narrower beat could still
  // produce a negative correction
  assign new_pkt_len =
      {{(tlp_hdr_pkg::len_width - 3){overhead[3]}}, overhead[2:0]} +
      {{(tlp_hdr_pkg::len_width - tlp_hdr_pkg::length_field_width){1'b0}}, payload_len};

endmodule

/* null_len_tracker.sv */
module null_len_tracker (
  input  logic                              user_clk,
  input  logic                              user_rst,
  input  logic                              tvalid,
  input  logic                              tready,
  input  logic                              eof,
  input  logic [tlp_hdr_pkg::len_width-1:0] new_pkt_len,
  output logic [tlp_hdr_pkg::len_width-1:0] next_len
);

  typedef enum logic {
    st_idle,
    st_in_pkt
  } state_t;

  state_t                            state;
  state_t                            next_state;
  logic [tlp_hdr_pkg::len_width-1:0] reg_len;
  logic [tlp_hdr_pkg::len_width-1:0] len_dec;
  logic                              pkt_done;

  assign len_dec = reg_len - tlp_hdr_pkg::len_t'(rx_stream_pkg::beat_dwords);

  // what is left fits in the beat on the bus now
  assign pkt_done = (reg_len <= tlp_hdr_pkg::len_t'(rx_stream_pkg::beat_dwords));

  always_comb begin
    next_state = state;
    next_len   = reg_len;
    case (state)
      st_idle: begin
        // in idle the bus shows a header, so the count comes from the decoder
        next_len = new_pkt_len;
        if (tvalid && tready && !eof) begin
          next_state = st_in_pkt;
        end
      end
      st_in_pkt: begin
        if (tready && pkt_done) begin
          // the last beat is taken and the next beat starts a fresh packet
          next_len   = new_pkt_len;
          next_state = st_idle;
        end else if (tready) begin
          next_len = len_dec;
        end
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      state   <= st_idle;
      reg_len <= '0;
    end else begin
      state   <= next_state;
      reg_len <= next_len;
    end
  end

endmodule

/* null_beat_gen.sv */
module null_beat_gen (
  input  logic [tlp_hdr_pkg::len_width-1:0]   next_len,
  output logic                                null_rx_tvalid,
  output logic                                null_rx_tlast,
  output logic [rx_stream_pkg::keep_width-1:0] null_rx_tkeep,
  output logic                                null_rdst_rdy,
  output logic [4:0]                          null_is_eof
);

  logic [rx_stream_pkg::keep_width/2-1:0] upper_keep;

  // the null stream always offers a beat
  assign null_rx_tvalid = 1'b1;

  assign null_rx_tlast = (next_len <= tlp_hdr_pkg::len_t'(rx_stream_pkg::beat_dwords));
  assign null_rdst_rdy = null_rx_tlast;

  // the upper dword of a last beat is live only when two dwords remain
  assign upper_keep = (next_len == tlp_hdr_pkg::len_t'(rx_stream_pkg::beat_dwords)) ?
      '1 : '0;

  assign null_rx_tkeep = null_rx_tlast ?
      {upper_keep, {(rx_stream_pkg::keep_width / 2){1'b1}}} : '1;

  always_comb begin
    if (next_len == tlp_hdr_pkg::len_t'(1)) begin
      null_is_eof = rx_stream_pkg::eof_code_1dw;
    end else if (next_len == tlp_hdr_pkg::len_t'(2)) begin
      null_is_eof = rx_stream_pkg::eof_code_2dw;
    end else begin
      // more than one beat left, or a zero count, gives no end of frame
      null_is_eof = rx_stream_pkg::eof_code_none;
    end
  end

endmodule

/* rx_null_gen.sv */
module rx_null_gen (
  input  logic [rx_stream_pkg::data_width-1:0]  m_axis_rx_tdata,
  input  logic                                  m_axis_rx_tvalid,
  input  logic                                  m_axis_rx_tready,
  input  logic                                  m_axis_rx_tlast,
  input  logic [rx_stream_pkg::tuser_width-1:0] m_axis_rx_tuser,
  output logic                                  null_rx_tvalid,
  output logic                                  null_rx_tlast,
  output logic [rx_stream_pkg::keep_width-1:0]  null_rx_tkeep,
  output logic                                  null_rdst_rdy,
  output logic [4:0]                            null_is_eof,
  input  logic                                  user_clk,
  input  logic                                  user_rst
);

  logic [tlp_hdr_pkg::len_width-1:0] new_pkt_len;
  logic [tlp_hdr_pkg::len_width-1:0] next_len;
  logic                              eof;

  // tlast is ignored, the end of frame comes from tuser
  assign eof = m_axis_rx_tuser[rx_stream_pkg::tuser_eof_bit];

  tlp_len_decode u_decode (
    .tdata       (m_axis_rx_tdata),
    .new_pkt_len (new_pkt_len)
  );

  null_len_tracker u_tracker (
    .user_clk    (user_clk),
    .user_rst    (user_rst),
    .tvalid      (m_axis_rx_tvalid),
    .tready      (m_axis_rx_tready),
    .eof         (eof),
    .new_pkt_len (new_pkt_len),
    .next_len    (next_len)
  );

  null_beat_gen u_beat_gen (
    .next_len       (next_len),
    .null_rx_tvalid (null_rx_tvalid),
    .null_rx_tlast  (null_rx_tlast),
    .null_rx_tkeep  (null_rx_tkeep),
    .null_rdst_rdy  (null_rdst_rdy),
    .null_is_eof    (null_is_eof)
  );

endmodule

/* rx_null_checker.sv */
module rx_null_checker (
  input  logic       user_clk,
  input  logic       check_en,
  input  int         row_idx,
  input  logic       exp_tlast,
  input  logic [7:0] exp_tkeep,
  input  logic       exp_rdst_rdy,
  input  logic [4:0] exp_is_eof,
  input  logic       null_rx_tvalid,
  input  logic       null_rx_tlast,
  input  logic [7:0] null_rx_tkeep,
  input  logic       null_rdst_rdy,
  input  logic [4:0] null_is_eof,
  output int         error_count
);

  timeunit 1ns;
  timeprecision 100ps;

  int errors = 0;

  assign error_count = errors;

  task automatic check_field(input string name, input logic [7:0] got,
                             input logic [7:0] expected);
    if (got !== expected) begin
      $display("Fail %s row %0d: got 0x%h expected 0x%h", name, row_idx, got, expected);
      errors = errors + 1;
    end
  endtask

  // outputs settle by the falling edge, so look 1 ns after it,
  // which is 1 ns before the next rising edge
  always @(negedge user_clk) begin
    #1;
    if (check_en) begin
      check_field("null_rx_tvalid", {7'b0, null_rx_tvalid}, 8'h01);
      check_field("null_rx_tlast", {7'b0, null_rx_tlast}, {7'b0, exp_tlast});
      check_field("null_rx_tkeep", null_rx_tkeep, exp_tkeep);
      check_field("null_rdst_rdy", {7'b0, null_rdst_rdy}, {7'b0, exp_rdst_rdy});
      check_field("null_is_eof", {3'b0, null_is_eof}, {3'b0, exp_is_eof});
    end
  end

endmodule

/* rx_null_gen_tb.sv */
module rx_null_gen_tb;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [1:0] fmt;
    logic       td;
    logic [9:0] len;
    logic       tvalid;
    logic       tready;
    logic       eof;
    logic       exp_tlast;
    logic [7:0] exp_tkeep;
    logic       exp_rdy;
    logic [4:0] exp_eof;
  } row_t;

  logic        user_clk = 1'b0;
  logic        user_rst;
  logic [63:0] m_axis_rx_tdata;
  logic        m_axis_rx_tvalid;
  logic        m_axis_rx_tready;
  logic        m_axis_rx_tlast;
  logic [21:0] m_axis_rx_tuser;
  logic        null_rx_tvalid;
  logic        null_rx_tlast;
  logic [7:0]  null_rx_tkeep;
  logic        null_rdst_rdy;
  logic [4:0]  null_is_eof;
  logic        check_en;
  logic        exp_tlast;
  logic [7:0]  exp_tkeep;
  logic        exp_rdst_rdy;
  logic [4:0]  exp_is_eof;
  logic        table_ready = 1'b0;
  int          row_idx;
  int          error_count;
  row_t        rows[$];

  always #2 user_clk = ~user_clk;

  rx_null_gen DUT (
    .m_axis_rx_tdata  (m_axis_rx_tdata),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tready (m_axis_rx_tready),
    .m_axis_rx_tlast  (m_axis_rx_tlast),
    .m_axis_rx_tuser  (m_axis_rx_tuser),
    .null_rx_tvalid   (null_rx_tvalid),
    .null_rx_tlast    (null_rx_tlast),
    .null_rx_tkeep    (null_rx_tkeep),
    .null_rdst_rdy    (null_rdst_rdy),
    .null_is_eof      (null_is_eof),
    .user_clk         (user_clk),
    .user_rst         (user_rst)
  );

  rx_null_checker u_checker (
    .user_clk       (user_clk),
    .check_en       (check_en),
    .row_idx        (row_idx),
    .exp_tlast      (exp_tlast),
    .exp_tkeep      (exp_tkeep),
    .exp_rdst_rdy   (exp_rdst_rdy),
    .exp_is_eof     (exp_is_eof),
    .null_rx_tvalid (null_rx_tvalid),
    .null_rx_tlast  (null_rx_tlast),
    .null_rx_tkeep  (null_rx_tkeep),
    .null_rdst_rdy  (null_rdst_rdy),
    .null_is_eof    (null_is_eof),
    .error_count    (error_count)
  );

  // random filler everywhere except fmt, TD and length of the first dword
  function automatic logic [63:0] header_beat(input logic [1:0] fmt, input logic td,
                                              input logic [9:0] len);
    logic [63:0] beat;
    beat = {$urandom, $urandom};
    beat[30:29] = fmt;
    beat[15] = td;
    beat[9:0] = len;
    return beat;
  endfunction

  task automatic add_row(input logic [1:0] fmt, input logic td, input logic [9:0] len,
                         input logic tvalid, input logic tready, input logic eof,
                         input logic tlast, input logic [7:0] tkeep, input logic rdy,
                         input logic [4:0] is_eof);
    row_t r;
    r = {fmt, td, len, tvalid, tready, eof, tlast, tkeep, rdy, is_eof};
    rows.push_back(r);
  endtask

  task automatic apply_row(input int idx);
    logic [31:0] user_bits;
    user_bits = $urandom;
    m_axis_rx_tdata  = header_beat(rows[idx].fmt, rows[idx].td, rows[idx].len);
    m_axis_rx_tvalid = rows[idx].tvalid;
    m_axis_rx_tready = rows[idx].tready;
    m_axis_rx_tlast  = rows[idx].eof;
    m_axis_rx_tuser  = {rows[idx].eof, user_bits[20:0]};
    exp_tlast        = rows[idx].exp_tlast;
    exp_tkeep        = rows[idx].exp_tkeep;
    exp_rdst_rdy     = rows[idx].exp_rdy;
    exp_is_eof       = rows[idx].exp_eof;
    row_idx          = idx;
    check_en         = 1'b1;
  endtask

  // columns are fmt, td, length, tvalid, tready, eof, then expected
  // tlast, tkeep, rdst_rdy and is_eof
  task automatic fill_table();
    // idle after reset, 3-dword header without data
    add_row(2'b00, 1'b0, 10'h007, 1'b0, 1'b1, 1'b0, 1'b1, 8'h0f, 1'b1, 5'h13);
    // 4-dword header, digest, 5 data dwords, with back-pressure in the middle
    add_row(2'b11, 1'b1, 10'h005, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b0, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b0, 1'b0, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b10, 1'b1, 10'h3ff, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h0f, 1'b1, 5'h13);
    // a beat with end of frame in idle leaves the machine idle
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b1, 1'b1, 8'h0f, 1'b1, 5'h13);
    add_row(2'b10, 1'b0, 10'h003, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    // back-to-back packets of different header kinds
    add_row(2'b01, 1'b1, 10'h155, 1'b1, 1'b1, 1'b1, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b10, 1'b1, 10'h002, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b11, 1'b0, 10'h001, 1'b1, 1'b1, 1'b1, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b11, 1'b0, 10'h001, 1'b1, 1'b1, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b0, 10'h000, 1'b1, 1'b1, 1'b0, 1'b1, 8'h0f, 1'b1, 5'h13);
    // 4-dword header without data ignores the length field
    add_row(2'b01, 1'b0, 10'h3ff, 1'b1, 1'b1, 1'b1, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b01, 1'b0, 10'h3ff, 1'b1, 1'b1, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b10, 1'b0, 10'h009, 1'b1, 1'b0, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b10, 1'b1, 10'h009, 1'b1, 1'b1, 1'b1, 1'b0, 8'hff, 1'b0, 5'h03);
    add_row(2'b00, 1'b1, 10'h000, 1'b0, 1'b1, 1'b0, 1'b1, 8'hff, 1'b1, 5'h17);
    add_row(2'b10, 1'b0, 10'h3ff, 1'b1, 1'b0, 1'b0, 1'b0, 8'hff, 1'b0, 5'h03);
  endtask

  initial begin
    void'($urandom(15));
    user_rst         = 1'b1;
    m_axis_rx_tdata  = '0;
    m_axis_rx_tvalid = 1'b0;
    m_axis_rx_tready = 1'b0;
    m_axis_rx_tlast  = 1'b0;
    m_axis_rx_tuser  = '0;
    check_en         = 1'b0;
    exp_tlast        = 1'b0;
    exp_tkeep        = '0;
    exp_rdst_rdy     = 1'b0;
    exp_is_eof       = '0;
    row_idx          = 0;
    fill_table();
    table_ready = 1'b1;
    repeat (2) @(posedge user_clk);
    #1;
    user_rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i);
      @(posedge user_clk);
      #1;
    end
    check_en = 1'b0;
    $display("rows applied: %0d, errors: %0d", rows.size(), error_count);
    if (error_count == 0 && rows.size() > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // the whole table plus a margin of ten clock periods
  initial begin
    wait (table_ready);
    #((rows.size() + 10) * 4);
    $display("timeout: the stimulus table did not complete in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* rx_null_gen.f */
rx_stream_pkg.sv
tlp_hdr_pkg.sv
tlp_len_decode.sv
null_len_tracker.sv
null_beat_gen.sv
rx_null_gen.sv
rx_null_checker.sv
rx_null_gen_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module rx_null_gen_tb \
  -f rx_null_gen.f -o rx_null_gen_sim || exit 1
sim_out=$(./obj_dir/rx_null_gen_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "RESULT: PASS" && exit 0 || exit 1
